// File: rtl/l2_arb_pkg.sv
`default_nettype none

package l2_arb_pkg;

    ////////////////////
    // Line and address geometry
    ////////////////////

    localparam int LINE_W           = 256;  // Bits per cache line
    localparam int ADDR_W           = 32;   // Byte address width
    localparam int LINE_OFFSET_BITS = 5;    // Byte offset within a 32-byte line

    typedef logic [LINE_W-1:0] line_t;
    typedef logic [ADDR_W-1:0] addr_t;

    ////////////////////
    // Cache request payloads
    ////////////////////

    // Instruction side only reads, so the address is all it carries
    typedef struct packed {
        addr_t addr;
    } inst_req_t;

    typedef struct packed {
        logic  we;     // High for a line write
        addr_t addr;
        line_t wdata;  // Ignored on reads
    } data_req_t;

    ////////////////////
    // Arbiter to store
    ////////////////////

    // Same field order as data_req_t
    typedef struct packed {
        logic  we;
        addr_t addr;
        line_t wdata;
    } store_cmd_t;

endpackage

`default_nettype wire

// File: rtl/req_channel.sv
`timescale 1ns/1ps
`default_nettype none

module req_channel
    import l2_arb_pkg::*;
#(
    parameter type payload_t = logic
) (
    input  logic     clk,
    input  logic     rst_n,

    // Cache side, four-phase
    input  logic     req,
    input  payload_t payload,
    output logic     ack,
    output line_t    rdata,

    // Arbiter side
    output logic     pend,
    output payload_t held,
    input  logic     done,
    input  line_t    rsp_line
);

    typedef enum logic [1:0] {
        WAIT_REQ,
        PENDING,
        ACKED
    } state_t;

    state_t state;

    ////////////////////
    // Handshake sequencing
    ////////////////////

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            state <= WAIT_REQ;
        end else begin
            case (state)
                WAIT_REQ: begin
                    if (req) begin
                        state <= PENDING;  // Payload captured at this edge too
                    end
                end
                PENDING: begin
                    if (done) begin
                        state <= ACKED;
                    end
                end
                ACKED: begin
                    // A cache holding req here stalls only this channel
                    if (!req) begin
                        state <= WAIT_REQ;
                    end
                end
                default: begin
                    state <= WAIT_REQ;
                end
            endcase
        end
    end

    ////////////////////
    // Payload and response registers
    ////////////////////

    always_ff @(posedge clk) begin
        if (state == WAIT_REQ && req) begin
            held <= payload;
        end
        if (state == PENDING && done) begin
            rdata <= rsp_line;  // Stays valid for as long as ack is high
        end
    end

    assign pend = (state == PENDING);
    assign ack  = (state == ACKED);

    ////////////////////
    // Checks
    ////////////////////

    // The cache must still be holding req when its ack comes up
    ack_needs_req: assert property (@(posedge clk) disable iff (!rst_n)
        $rose(ack) |-> req)
        else $error("req_channel: ack rose while req was low");

    // The arbiter may only complete a request this channel has posted
    done_needs_pend: assert property (@(posedge clk) disable iff (!rst_n)
        done |-> pend)
        else $error("req_channel: done arrived with no pending request");

endmodule

`default_nettype wire

// File: rtl/cache_arbiter.sv
`timescale 1ns/1ps
`default_nettype none

module cache_arbiter
    import l2_arb_pkg::*;
(
    input  logic       clk,
    input  logic       rst_n,

    // Instruction channel
    input  logic       i_pend,
    input  inst_req_t  i_req,
    output logic       i_done,

    // Data channel
    input  logic       d_pend,
    input  data_req_t  d_req,
    output logic       d_done,

    // Response line shared by both channels and valid with a done pulse
    output line_t      rsp_line,

    // Line store, four-phase
    output logic       st_req,
    output store_cmd_t st_cmd,
    input  logic       st_ack,
    input  line_t      st_rdata
);

    typedef enum logic [1:0] {
        IDLE,
        BUSY,
        RELEASE
    } state_t;

    state_t     state;
    logic       grant_d;  // High when the data side owns the store

    ////////////////////
    // Command of the granted side
    ////////////////////

    // Instruction requests always become reads
    always_comb begin
        if (!grant_d) begin
            st_cmd.we    = 1'b0;
            st_cmd.addr  = i_req.addr;
            st_cmd.wdata = '0;
        end else begin
            st_cmd.we    = d_req.we;
            st_cmd.addr  = d_req.addr;
            st_cmd.wdata = d_req.wdata;
        end
    end

    ////////////////////
    // Grant FSM
    ////////////////////

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            state   <= IDLE;
            grant_d <= 1'b0;
            st_req  <= 1'b0;
            i_done  <= 1'b0;
            d_done  <= 1'b0;
        end else begin
            i_done <= 1'b0;  // Done is a single-cycle pulse
            d_done <= 1'b0;
            case (state)
                IDLE: begin
                    if (i_pend || d_pend) begin
                        grant_d <= !i_pend;  // Instruction side wins a tie
                        st_req  <= 1'b1;
                        state   <= BUSY;
                    end
                end
                BUSY: begin
                    if (st_ack) begin
                        st_req <= 1'b0;
                        i_done <= !grant_d;
                        d_done <= grant_d;
                        state  <= RELEASE;
                    end
                end
                RELEASE: begin
                    // Pend has dropped by the time ack falls and nothing is regranted
                    if (!st_ack) begin
                        state <= IDLE;
                    end
                end
                default: begin
                    state <= IDLE;
                end
            endcase
        end
    end

    always_ff @(posedge clk) begin
        if (state == BUSY && st_ack) begin
            rsp_line <= st_rdata;
        end
    end

    // The store samples the command over several cycles
    cmd_stable: assert property (@(posedge clk) disable iff (!rst_n)
        st_req && $past(st_req) |-> $stable(st_cmd))
        else $error("cache_arbiter: st_cmd changed while st_req was high");

endmodule

`default_nettype wire

// File: rtl/line_store.sv
`timescale 1ns/1ps
`default_nettype none

module line_store
    import l2_arb_pkg::*;
#(
    parameter int LINES   = 16,
    parameter int LATENCY = 4
) (
    input  logic       clk,
    input  logic       rst_n,

    input  logic       req,
    input  store_cmd_t cmd,
    output logic       ack,
    output line_t      rdata
);

    localparam int IDX_W = $clog2(LINES);
    localparam int CNT_W = $clog2(LATENCY + 1);
    localparam logic [CNT_W-1:0] CNT_LAST = CNT_W'(LATENCY);

    typedef enum logic [1:0] {
        ST_IDLE,
        ST_COUNT,
        ST_ACK
    } state_t;

    state_t           state;
    logic [CNT_W-1:0] cnt;
    logic [IDX_W-1:0] idx;
    line_t            mem [LINES];

    // Upper address bits alias onto the same line
    assign idx = cmd.addr[LINE_OFFSET_BITS +: IDX_W];

    ////////////////////
    // Latency counter and handshake
    ////////////////////

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            state <= ST_IDLE;
            cnt   <= '0;
        end else begin
            case (state)
                ST_IDLE: begin
                    if (req) begin
                        cnt   <= CNT_W'(1);
                        state <= ST_COUNT;
                    end
                end
                ST_COUNT: begin
                    if (cnt == CNT_LAST) begin
                        state <= ST_ACK;  // Access happens on this edge
                    end else begin
                        cnt <= cnt + 1'b1;
                    end
                end
                ST_ACK: begin
                    if (!req) begin
                        state <= ST_IDLE;
                    end
                end
                default: begin
                    state <= ST_IDLE;
                end
            endcase
        end
    end

    ////////////////////
    // Line array
    ////////////////////

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            mem <= '{default: '0};
        end else if (state == ST_COUNT && cnt == CNT_LAST && cmd.we) begin
            mem[idx] <= cmd.wdata;
        end
    end

    // Read sees the line as it was before a write in the same access
    always_ff @(posedge clk) begin
        if (state == ST_COUNT && cnt == CNT_LAST) begin
            rdata <= mem[idx];
        end
    end

    assign ack = (state == ST_ACK);

endmodule

`default_nettype wire

// File: rtl/l2_arb_top.sv
`timescale 1ns/1ps
`default_nettype none

module l2_arb_top
    import l2_arb_pkg::*;
#(
    parameter int LINES   = 16,
    parameter int LATENCY = 4
) (
    input  logic      clk,
    input  logic      rst_n,

    // Instruction cache port
    input  logic      icache_req,
    input  inst_req_t icache_cmd,
    output logic      icache_ack,
    output line_t     icache_rdata,

    // Data cache port
    input  logic      dcache_req,
    input  data_req_t dcache_cmd,
    output logic      dcache_ack,
    output line_t     dcache_rdata
);

    logic       i_pend;
    inst_req_t  i_held;
    logic       i_done;
    logic       d_pend;
    data_req_t  d_held;
    logic       d_done;
    line_t      rsp_line;
    logic       st_req;
    store_cmd_t st_cmd;
    logic       st_ack;
    line_t      st_rdata;

    ////////////////////
    // Cache channels
    ////////////////////

    req_channel #(
        .payload_t (inst_req_t)
    ) u_ichan (
        .clk      (clk),
        .rst_n    (rst_n),
        .req      (icache_req),
        .payload  (icache_cmd),
        .ack      (icache_ack),
        .rdata    (icache_rdata),
        .pend     (i_pend),
        .held     (i_held),
        .done     (i_done),
        .rsp_line (rsp_line)
    );

    req_channel #(
        .payload_t (data_req_t)
    ) u_dchan (
        .clk      (clk),
        .rst_n    (rst_n),
        .req      (dcache_req),
        .payload  (dcache_cmd),
        .ack      (dcache_ack),
        .rdata    (dcache_rdata),
        .pend     (d_pend),
        .held     (d_held),
        .done     (d_done),
        .rsp_line (rsp_line)
    );

    ////////////////////
    // Arbiter and store
    ////////////////////

    cache_arbiter u_arb (
        .clk      (clk),
        .rst_n    (rst_n),
        .i_pend   (i_pend),
        .i_req    (i_held),
        .i_done   (i_done),
        .d_pend   (d_pend),
        .d_req    (d_held),
        .d_done   (d_done),
        .rsp_line (rsp_line),
        .st_req   (st_req),
        .st_cmd   (st_cmd),
        .st_ack   (st_ack),
        .st_rdata (st_rdata)
    );

    line_store #(
        .LINES   (LINES),
        .LATENCY (LATENCY)
    ) u_store (
        .clk   (clk),
        .rst_n (rst_n),
        .req   (st_req),
        .cmd   (st_cmd),
        .ack   (st_ack),
        .rdata (st_rdata)
    );

endmodule

`default_nettype wire

// File: tb/tb_checker.sv
`timescale 1ns/1ps
`default_nettype none

module tb_checker
    import l2_arb_pkg::*;
#(
    parameter int LINES = 16
) (
    input  logic      clk,
    input  logic      rst_n,
    input  logic      icache_req,
    input  inst_req_t icache_cmd,
    input  logic      icache_ack,
    input  line_t     icache_rdata,
    input  logic      dcache_req,
    input  data_req_t dcache_cmd,
    input  logic      dcache_ack,
    input  line_t     dcache_rdata,
    output int        errors,
    output int        reads_checked,
    output int        writes_seen,
    output int        ties_seen
);

    line_t     model [LINES];
    logic      i_req_q;
    logic      i_ack_q;
    logic      i_open;
    logic      d_req_q;
    logic      d_ack_q;
    logic      d_open;
    logic      tie_open;  // Set when both requests arrive together and icache must finish first
    inst_req_t i_txn;
    data_req_t d_txn;

    // Upper address bits fold onto the same line
    function automatic int line_of(input addr_t addr);
        return int'((addr >> LINE_OFFSET_BITS) % LINES);
    endfunction

    task automatic report(input string what);
        errors++;
        $display("ERROR t=%0t %s", $time, what);
    endtask

    task automatic check_line(input string sig, input line_t expected, input line_t actual);
        reads_checked++;
        if (actual !== expected) begin
            errors++;
            $display("FAIL t=%0t %s expected=%h actual=%h", $time, sig, expected, actual);
        end
    endtask

    task automatic check_handshake(input string port, input logic req, input logic ack,
                                   input logic req_q, input logic ack_q);
        if (ack && !ack_q && !req) begin
            report({port, " ack rose while req was low"});
        end
        if (!ack && ack_q && req_q) begin
            report({port, " ack fell while req was still high"});
        end
        if (ack && ack_q && !req_q) begin
            report({port, " ack stayed high after req was seen low"});
        end
    endtask

    ////////////////////
    // Port monitor sampled away from the clock edge
    ////////////////////

    always @(negedge clk) begin
        if (!rst_n) begin
            for (int k = 0; k < LINES; k++) begin
                model[k] = '0;
            end
            i_req_q  = 1'b0;
            i_ack_q  = 1'b0;
            i_open   = 1'b0;
            d_req_q  = 1'b0;
            d_ack_q  = 1'b0;
            d_open   = 1'b0;
            tie_open = 1'b0;
        end else begin
            check_handshake("icache", icache_req, icache_ack, i_req_q, i_ack_q);
            check_handshake("dcache", dcache_req, dcache_ack, d_req_q, d_ack_q);

            if (icache_req && !i_req_q && dcache_req && !d_req_q && !i_open && !d_open
                && !icache_ack && !dcache_ack) begin
                tie_open = 1'b1;
                ties_seen++;
            end

            if (icache_req && !i_req_q) begin
                i_open = 1'b1;
                i_txn  = icache_cmd;
            end
            if (dcache_req && !d_req_q) begin
                d_open = 1'b1;
                d_txn  = dcache_cmd;
            end

            // Ack rises give the store order and only one side completes per cycle
            if (icache_ack && !i_ack_q) begin
                if (!i_open) begin
                    report("icache_ack rose with no open request");
                end else begin
                    check_line("icache_rdata", model[line_of(i_txn.addr)], icache_rdata);
                end
                i_open   = 1'b0;
                tie_open = 1'b0;
            end
            if (dcache_ack && !d_ack_q) begin
                if (tie_open) begin
                    report("dcache_ack rose before icache_ack after a same-cycle request");
                end
                if (!d_open) begin
                    report("dcache_ack rose with no open request");
                end else if (d_txn.we) begin
                    model[line_of(d_txn.addr)] = d_txn.wdata;
                    writes_seen++;
                end else begin
                    check_line("dcache_rdata", model[line_of(d_txn.addr)], dcache_rdata);
                end
                d_open = 1'b0;
            end

            i_req_q = icache_req;
            i_ack_q = icache_ack;
            d_req_q = dcache_req;
            d_ack_q = dcache_ack;
        end
    end

endmodule

`default_nettype wire

// File: tb/tb_top.sv
`timescale 1ns/1ps
`default_nettype none

module tb_top
    import l2_arb_pkg::*;
();

    localparam int LINES          = 16;
    localparam int LATENCY        = 4;
    localparam int NUM_TXN        = 300;  // Per cache
    localparam int RESET_CYCLES   = 5;
    localparam int IDX_W          = $clog2(LINES);
    localparam int TIMEOUT_CYCLES = 2 * NUM_TXN * (LATENCY + 12) + RESET_CYCLES;
    localparam logic [31:0] SEED  = 32'h7e3a;

    logic      clk;
    logic      rst_n;
    logic      icache_req;
    inst_req_t icache_cmd;
    logic      icache_ack;
    line_t     icache_rdata;
    logic      dcache_req;
    data_req_t dcache_cmd;
    logic      dcache_ack;
    line_t     dcache_rdata;

    logic i_finished = 1'b0;
    logic d_finished = 1'b0;
    int   cycles     = 0;
    int   errors;
    int   reads_checked;
    int   writes_seen;
    int   ties_seen;

    function automatic logic [31:0] lcg_next(input logic [31:0] state);
        return state * 32'd1664525 + 32'd1013904223;
    endfunction

    // Random upper and offset bits around a line index from a small set
    function automatic addr_t pick_addr(input logic [31:0] noise, input logic [2:0] line_sel);
        addr_t addr;
        addr = noise;
        addr[LINE_OFFSET_BITS +: IDX_W] = IDX_W'(line_sel);
        return addr;
    endfunction

    task automatic print_summary();
        $display("Errors: %0d (reads checked %0d, writes %0d, same-cycle ties %0d, cycles %0d)",
                 errors, reads_checked, writes_seen, ties_seen, cycles);
    endtask

    ////////////////////
    // Clock and reset
    ////////////////////

    initial begin
        clk = 1'b0;
        forever #50 clk = ~clk;
    end

    initial begin
        rst_n <= 1'b0;
        repeat (RESET_CYCLES) @(posedge clk);
        rst_n <= 1'b1;
    end

    l2_arb_top #(
        .LINES   (LINES),
        .LATENCY (LATENCY)
    ) DUT (
        .clk          (clk),
        .rst_n        (rst_n),
        .icache_req   (icache_req),
        .icache_cmd   (icache_cmd),
        .icache_ack   (icache_ack),
        .icache_rdata (icache_rdata),
        .dcache_req   (dcache_req),
        .dcache_cmd   (dcache_cmd),
        .dcache_ack   (dcache_ack),
        .dcache_rdata (dcache_rdata)
    );

    tb_checker #(
        .LINES (LINES)
    ) u_checker (
        .clk           (clk),
        .rst_n         (rst_n),
        .icache_req    (icache_req),
        .icache_cmd    (icache_cmd),
        .icache_ack    (icache_ack),
        .icache_rdata  (icache_rdata),
        .dcache_req    (dcache_req),
        .dcache_cmd    (dcache_cmd),
        .dcache_ack    (dcache_ack),
        .dcache_rdata  (dcache_rdata),
        .errors        (errors),
        .reads_checked (reads_checked),
        .writes_seen   (writes_seen),
        .ties_seen     (ties_seen)
    );

    ////////////////////
    // Cache traffic
    ////////////////////

    initial begin : icache_driver
        logic [31:0] rng;
        logic [2:0]  line_sel;
        int          gap;
        int          hold;
        inst_req_t   cmd;
        rng = SEED;
        icache_req <= 1'b0;
        icache_cmd <= '0;
        wait (rst_n);
        @(posedge clk);
        for (int n = 0; n < NUM_TXN; n++) begin
            rng      = lcg_next(rng);
            gap      = int'(rng[31:30]);
            hold     = int'(rng[29:28]);  // Extra cycles req stays up after ack
            line_sel = rng[27:25];
            rng      = lcg_next(rng);
            cmd.addr = pick_addr(rng, line_sel);
            repeat (gap) @(posedge clk);
            icache_req <= 1'b1;
            icache_cmd <= cmd;
            @(posedge clk);
            while (!icache_ack) @(posedge clk);
            repeat (hold) @(posedge clk);
            icache_req <= 1'b0;
            icache_cmd <= inst_req_t'(~rng);  // Payload is free once req drops
            @(posedge clk);
            while (icache_ack) @(posedge clk);
        end
        i_finished = 1'b1;
    end

    initial begin : dcache_driver
        logic [31:0] rng;
        logic [2:0]  line_sel;
        int          gap;
        int          hold;
        data_req_t   cmd;
        rng = SEED ^ 32'hffff_ffff;
        dcache_req <= 1'b0;
        dcache_cmd <= '0;
        wait (rst_n);
        @(posedge clk);
        for (int n = 0; n < NUM_TXN; n++) begin
            rng      = lcg_next(rng);
            gap      = int'(rng[31:30]);
            hold     = int'(rng[29:28]);
            line_sel = rng[27:25];
            cmd.we   = rng[24];
            rng      = lcg_next(rng);
            cmd.addr = pick_addr(rng, line_sel);
            for (int k = 0; k < LINE_W / 32; k++) begin
                rng = lcg_next(rng);
                cmd.wdata[32*k +: 32] = rng;
            end
            repeat (gap) @(posedge clk);
            dcache_req <= 1'b1;
            dcache_cmd <= cmd;
            @(posedge clk);
            while (!dcache_ack) @(posedge clk);
            repeat (hold) @(posedge clk);
            cmd.we   = !cmd.we;
            cmd.addr = cmd.addr ^ rng;
            dcache_req <= 1'b0;
            dcache_cmd <= cmd;
            @(posedge clk);
            while (dcache_ack) @(posedge clk);
        end
        d_finished = 1'b1;
    end

    ////////////////////
    // End of run
    ////////////////////

    always @(posedge clk) begin
        cycles <= cycles + 1;
        if (cycles >= TIMEOUT_CYCLES) begin
            $display("Timeout: cache traffic did not finish within %0d cycles", TIMEOUT_CYCLES);
            print_summary();
            $display("Test FAILED");
            $finish;
        end
    end

    initial begin : end_of_run
        wait (i_finished && d_finished);
        repeat (4) @(posedge clk);
        print_summary();
        if (errors == 0) begin
            $display("Test OK");
        end else begin
            $display("Test FAILED");
        end
        $finish;
    end

endmodule

`default_nettype wire

// File: sources.f
rtl/l2_arb_pkg.sv
rtl/req_channel.sv
rtl/cache_arbiter.sv
rtl/line_store.sv
rtl/l2_arb_top.sv
tb/tb_checker.sv
tb/tb_top.sv

// File: run.sh
#!/usr/bin/env bash
# Build the testbench with Verilator, run it and scan the log for the fail message

cd "$(dirname "$0")" || exit 1
rm -rf obj_dir sim.log

verilator --binary --timing --assert -j 0 --top-module tb_top -f sources.f -o tb_sim \
    || { echo "Verilator build failed"; exit 1; }

./obj_dir/tb_sim > sim.log 2>&1 \
    || { cat sim.log; echo "Simulation exited abnormally"; exit 1; }

cat sim.log
grep -q "Test FAILED" sim.log && { echo "Simulation reported a failure"; exit 1; }
grep -q "Test OK" sim.log || { echo "No pass message found in sim.log"; exit 1; }
exit 0
